//--- logic/intra4_pkg.sv
//----------------------------------------------------------------------
// Intra 4x4 mode decision shared definitions
//----------------------------------------------------------------------
package intra4_pkg;

    // Block geometry
    localparam int NUM_MODES = 4;
    localparam int NUM_SUB   = 16;

    // One luma sample
    typedef logic [7:0] pixel_t;

    // 4x4 subblock, pixel (c,r) at r*4+c
    typedef pixel_t [15:0] blk4_t;

    // 16x16 macroblock, pixel (x,y) at y*16+x
    typedef pixel_t [255:0] mb_t;

    // Input edges of the macroblock
    typedef pixel_t [19:0] top_edge_t;
    typedef pixel_t [15:0] left_edge_t;

    // Neighbor context of one subblock
    typedef struct packed {
        pixel_t       top_left;
        pixel_t [3:0] top;
        pixel_t       top_right;
        pixel_t [3:0] left;
    } i4_ctx_t;

    typedef blk4_t [NUM_MODES-1:0] i4_preds_t;

    typedef logic [1:0]  mode_t;
    typedef logic [3:0]  sub_idx_t;
    typedef logic [15:0] hdr_cost_t;
    typedef logic [31:0] sse_t;
    typedef logic [31:0] lambda_t;
    typedef logic [63:0] score_t;

    typedef score_t [NUM_MODES-1:0] mode_scores_t;
    typedef mode_t  [NUM_SUB-1:0]   mb_modes_t;

    // Mode indices
    localparam mode_t MODE_DC = 2'd0;
    localparam mode_t MODE_TM = 2'd1;
    localparam mode_t MODE_VE = 2'd2;
    localparam mode_t MODE_HE = 2'd3;

    // Header cost per mode, indexed by mode_t
    localparam hdr_cost_t [NUM_MODES-1:0] FIXED_COST = {
        16'd1874, 16'd1723, 16'd1151, 16'd40
    };

    localparam int MODE_BASE_COST = 211;

    // SSE weight is 1 << SSE_SHIFT
    localparam int SSE_SHIFT = 8;

endpackage

//--- logic/intra4_ctrl.sv
//----------------------------------------------------------------------
// Intra 4x4 subblock sequencer
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    output logic                 ctx_en_o,
    output logic                 pred_en_o,
    output logic                 score_en_o,
    output logic                 store_en_o,
    output logic                 first_o,
    output intra4_pkg::sub_idx_t sub_o,
    output logic                 done_o
);
    import intra4_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, PRED, SCORE, STORE, DONE} state_t;

    localparam sub_idx_t LAST_SUB = sub_idx_t'(NUM_SUB - 1);

    state_t   state_q;
    state_t   state_d;
    sub_idx_t sub_q;
    logic     done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = LOAD;
            LOAD:    state_d = PRED;
            PRED:    state_d = SCORE;
            SCORE:   state_d = STORE;
            STORE:   state_d = (sub_q == LAST_SUB) ? DONE : LOAD;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            sub_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == DONE);
            if (first_o) begin
                sub_q <= '0;
            end else if (store_en_o && sub_q != LAST_SUB) begin
                sub_q <= sub_q + 4'd1;
            end
        end
    end

    // One strobe per pipeline stage
    assign ctx_en_o   = (state_q == LOAD);
    assign pred_en_o  = (state_q == PRED);
    assign score_en_o = (state_q == SCORE);
    assign store_en_o = (state_q == STORE);
    assign first_o    = (state_q == IDLE) && start_i;
    assign sub_o      = sub_q;
    assign done_o     = done_q;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o);

    sub_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != IDLE && $past(state_q) != IDLE) |-> sub_q >= $past(sub_q));

endmodule

//--- logic/intra4_context.sv
//----------------------------------------------------------------------
// Intra 4x4 source and neighbor fetch
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_context (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ctx_en_i,
    input  intra4_pkg::sub_idx_t   sub_i,
    input  intra4_pkg::mb_t        ysrc_i,
    input  intra4_pkg::top_edge_t  top_i,
    input  intra4_pkg::left_edge_t left_i,
    input  intra4_pkg::pixel_t     top_left_i,
    input  intra4_pkg::mb_t        recon_i,
    output intra4_pkg::blk4_t      src_o,
    output intra4_pkg::i4_ctx_t    ctx_o
);
    import intra4_pkg::*;

    // Subblock origin in the macroblock
    logic [3:0] x0;
    logic [3:0] y0;

    blk4_t   src_c;
    i4_ctx_t ctx_c;
    blk4_t   src_q;
    i4_ctx_t ctx_q;

    assign x0 = {sub_i[1:0], 2'b00};
    assign y0 = {sub_i[3:2], 2'b00};

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                src_c[r*4+c] = ysrc_i[(y0 + r) * 16 + x0 + c];
            end
        end

        // Top row from the edge or the row above
        for (int c = 0; c < 4; c++) begin
            ctx_c.top[c] = (y0 == 0) ? top_i[x0 + c] : recon_i[(y0 - 1) * 16 + x0 + c];
        end

        // Left column from the edge or the column to the left
        for (int r = 0; r < 4; r++) begin
            ctx_c.left[r] = (x0 == 0) ? left_i[y0 + r] : recon_i[(y0 + r) * 16 + x0 - 1];
        end

        if (x0 == 0 && y0 == 0) begin
            ctx_c.top_left = top_left_i;
        end else if (y0 == 0) begin
            ctx_c.top_left = top_i[x0 - 1];
        end else if (x0 == 0) begin
            ctx_c.top_left = left_i[y0 - 1];
        end else begin
            ctx_c.top_left = recon_i[(y0 - 1) * 16 + x0 - 1];
        end

        // Right column of subblocks falls back to top byte 16
        if (y0 == 0) begin
            ctx_c.top_right = top_i[x0 + 4];
        end else if (x0 < 12) begin
            ctx_c.top_right = recon_i[(y0 - 1) * 16 + x0 + 4];
        end else begin
            ctx_c.top_right = top_i[16];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q <= '0;
            ctx_q <= '0;
        end else if (ctx_en_i) begin
            src_q <= src_c;
            ctx_q <= ctx_c;
        end
    end

    assign src_o = src_q;
    assign ctx_o = ctx_q;

endmodule

//--- logic/intra4_predict.sv
//----------------------------------------------------------------------
// Intra 4x4 DC, TM, VE and HE predictors
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_predict (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pred_en_i,
    input  intra4_pkg::i4_ctx_t   ctx_i,
    output intra4_pkg::i4_preds_t preds_o
);
    import intra4_pkg::*;

    // Rounded 1-2-1 smoothing
    function automatic pixel_t avg3(input pixel_t a, input pixel_t b, input pixel_t c);
        logic [9:0] s;
        s = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
        return s[9:2];
    endfunction

    function automatic pixel_t clip8(input logic signed [9:0] v);
        pixel_t res;
        if (v < 0) begin
            res = 8'd0;
        end else if (v > 10'sd255) begin
            res = 8'd255;
        end else begin
            res = v[7:0];
        end
        return res;
    endfunction

    // Edges extended by one sample at each end
    pixel_t [5:0] top_x;
    pixel_t [5:0] left_x;
    logic [10:0]  dc_sum;
    pixel_t       dc_val;
    logic signed [9:0] tm_val;

    i4_preds_t preds_c;
    i4_preds_t preds_q;

    always_comb begin
        top_x[0]  = ctx_i.top_left;
        left_x[0] = ctx_i.top_left;
        for (int k = 0; k < 4; k++) begin
            top_x[k+1]  = ctx_i.top[k];
            left_x[k+1] = ctx_i.left[k];
        end
        top_x[5]  = ctx_i.top_right;
        left_x[5] = ctx_i.left[3];

        dc_sum = 11'd4;
        for (int k = 0; k < 4; k++) begin
            dc_sum = dc_sum + {3'b000, ctx_i.top[k]} + {3'b000, ctx_i.left[k]};
        end
        dc_val = dc_sum[10:3];

        tm_val = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                tm_val = $signed({2'b00, ctx_i.top[c]}) + $signed({2'b00, ctx_i.left[r]})
                         - $signed({2'b00, ctx_i.top_left});
                preds_c[MODE_DC][r*4+c] = dc_val;
                preds_c[MODE_TM][r*4+c] = clip8(tm_val);
                preds_c[MODE_VE][r*4+c] = avg3(top_x[c], top_x[c+1], top_x[c+2]);
                preds_c[MODE_HE][r*4+c] = avg3(left_x[r], left_x[r+1], left_x[r+2]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            preds_q <= '0;
        end else if (pred_en_i) begin
            preds_q <= preds_c;
        end
    end

    assign preds_o = preds_q;

endmodule

//--- logic/intra4_score.sv
//----------------------------------------------------------------------
// Intra 4x4 SSE and mode score
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_score (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        pred_en_i,
    input  logic                                        score_en_i,
    input  intra4_pkg::blk4_t                           src_i,
    input  intra4_pkg::i4_preds_t                       preds_i,
    input  intra4_pkg::lambda_t                         lambda_i4_i,
    output intra4_pkg::mode_scores_t                    scores_o,
    output intra4_pkg::sse_t [intra4_pkg::NUM_MODES-1:0] sse_o
);
    import intra4_pkg::*;

    function automatic sse_t sse4(input blk4_t a, input blk4_t b);
        sse_t              acc;
        logic signed [8:0] d;
        logic [16:0]       sq;
        acc = '0;
        for (int k = 0; k < 16; k++) begin
            d   = $signed({1'b0, a[k]}) - $signed({1'b0, b[k]});
            sq  = d * d;
            acc = acc + sse_t'(sq);
        end
        return acc;
    endfunction

    blk4_t                  src_q;
    sse_t [NUM_MODES-1:0]   sse_c;
    mode_scores_t           scores_c;
    sse_t [NUM_MODES-1:0]   sse_q;
    mode_scores_t           scores_q;

    always_comb begin
        for (int m = 0; m < NUM_MODES; m++) begin
            sse_c[m]    = sse4(src_q, preds_i[m]);
            scores_c[m] = (score_t'(sse_c[m]) << SSE_SHIFT)
                          + score_t'(FIXED_COST[m]) * score_t'(lambda_i4_i);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q    <= '0;
            sse_q    <= '0;
            scores_q <= '0;
        end else begin
            // Source follows the predictions by one stage
            if (pred_en_i) begin
                src_q <= src_i;
            end
            if (score_en_i) begin
                sse_q    <= sse_c;
                scores_q <= scores_c;
            end
        end
    end

    assign scores_o = scores_q;
    assign sse_o    = sse_q;

endmodule

//--- logic/intra4_select.sv
//----------------------------------------------------------------------
// Intra 4x4 mode pick and reconstruction store
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_select (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        first_i,
    input  logic                                        score_en_i,
    input  logic                                        store_en_i,
    input  intra4_pkg::sub_idx_t                        sub_i,
    input  intra4_pkg::i4_preds_t                       preds_i,
    input  intra4_pkg::mode_scores_t                    scores_i,
    input  intra4_pkg::sse_t [intra4_pkg::NUM_MODES-1:0] sse_i,
    input  intra4_pkg::lambda_t                         lambda_mode_i,
    output intra4_pkg::mb_t                             recon_o,
    output intra4_pkg::mb_modes_t                       modes_o,
    output intra4_pkg::score_t                          score_o
);
    import intra4_pkg::*;

    i4_preds_t preds_q;
    sub_idx_t  sub_q;
    mode_t     best;
    score_t    best_score;
    score_t    blk_cost;
    logic [3:0] x0;
    logic [3:0] y0;

    mb_t       recon_q;
    mb_modes_t modes_q;
    score_t    score_q;

    // Strict compare keeps the lower mode on a tie
    always_comb begin
        best       = MODE_DC;
        best_score = scores_i[0];
        for (int m = 1; m < NUM_MODES; m++) begin
            if (scores_i[m] < best_score) begin
                best       = mode_t'(m);
                best_score = scores_i[m];
            end
        end
        blk_cost = (score_t'(sse_i[best]) << SSE_SHIFT)
                   + score_t'(FIXED_COST[best]) * score_t'(lambda_mode_i);
    end

    assign x0 = {sub_q[1:0], 2'b00};
    assign y0 = {sub_q[3:2], 2'b00};

    always_ff @(posedge clk) begin
        if (score_en_i) begin
            preds_q <= preds_i;
            sub_q   <= sub_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recon_q <= '0;
            modes_q <= '0;
            score_q <= '0;
        end else if (first_i) begin
            score_q <= score_t'(MODE_BASE_COST) * score_t'(lambda_mode_i);
        end else if (store_en_i) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    recon_q[(y0 + r) * 16 + x0 + c] <= preds_q[best][r*4+c];
                end
            end
            modes_q[sub_q] <= best;
            score_q        <= score_q + blk_cost;
        end
    end

    assign recon_o = recon_q;
    assign modes_o = modes_q;
    assign score_o = score_q;

    store_after_score: assert property (@(posedge clk) disable iff (!rst_n)
        store_en_i |-> !first_i && $past(score_en_i));

endmodule

//--- logic/intra4_top.sv
//----------------------------------------------------------------------
// Intra 4x4 mode decision top level
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  intra4_pkg::lambda_t    lambda_i4_i,
    input  intra4_pkg::lambda_t    lambda_mode_i,
    input  intra4_pkg::mb_t        ysrc_i,
    input  intra4_pkg::pixel_t     top_left_i,
    input  intra4_pkg::top_edge_t  top_i,
    input  intra4_pkg::left_edge_t left_i,
    output intra4_pkg::mb_t        yout_o,
    output intra4_pkg::mb_modes_t  modes_o,
    output intra4_pkg::score_t     score_o,
    output logic                   done_o
);
    import intra4_pkg::*;

    logic                 ctx_en;
    logic                 pred_en;
    logic                 score_en;
    logic                 store_en;
    logic                 first;
    sub_idx_t             sub;
    blk4_t                src;
    i4_ctx_t              ctx;
    i4_preds_t            preds;
    mode_scores_t         scores;
    sse_t [NUM_MODES-1:0] sse;

    intra4_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start_i(start_i),
        .ctx_en_o(ctx_en), .pred_en_o(pred_en), .score_en_o(score_en),
        .store_en_o(store_en), .first_o(first), .sub_o(sub), .done_o(done_o)
    );

    // Reconstruction feeds back as context for later subblocks
    intra4_context u_context (
        .clk(clk), .rst_n(rst_n), .ctx_en_i(ctx_en), .sub_i(sub),
        .ysrc_i(ysrc_i), .top_i(top_i), .left_i(left_i), .top_left_i(top_left_i),
        .recon_i(yout_o), .src_o(src), .ctx_o(ctx)
    );

    intra4_predict u_predict (
        .clk(clk), .rst_n(rst_n), .pred_en_i(pred_en), .ctx_i(ctx), .preds_o(preds)
    );

    intra4_score u_score (
        .clk(clk), .rst_n(rst_n), .pred_en_i(pred_en), .score_en_i(score_en),
        .src_i(src), .preds_i(preds), .lambda_i4_i(lambda_i4_i),
        .scores_o(scores), .sse_o(sse)
    );

    intra4_select u_select (
        .clk(clk), .rst_n(rst_n), .first_i(first), .score_en_i(score_en),
        .store_en_i(store_en), .sub_i(sub), .preds_i(preds), .scores_i(scores),
        .sse_i(sse), .lambda_mode_i(lambda_mode_i),
        .recon_o(yout_o), .modes_o(modes_o), .score_o(score_o)
    );

endmodule

//--- verif/tb_clock_gen.sv
//----------------------------------------------------------------------
// Testbench clock source
//----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

//--- verif/intra4_ref.svh
//----------------------------------------------------------------------
// Intra 4x4 mode decision reference model
//----------------------------------------------------------------------
`ifndef INTRA4_REF_SVH
`define INTRA4_REF_SVH

function automatic longint header_cost(input int m);
    longint cost;
    case (m)
        0:       cost = 40;
        1:       cost = 1151;
        2:       cost = 1723;
        default: cost = 1874;
    endcase
    return cost;
endfunction

function automatic int smooth3(input int a, input int b, input int c);
    return (a + 2 * b + c + 2) >> 2;
endfunction

// Walks all 16 subblocks in raster order, reconstruction feeding context
function automatic void ref_decide(
    input  mb_t        src,
    input  top_edge_t  top,
    input  left_edge_t left,
    input  pixel_t     corner,
    input  lambda_t    lam_i4,
    input  lambda_t    lam_mode,
    output mb_t        rec,
    output mb_modes_t  modes,
    output score_t     score
);
    int     x0;
    int     y0;
    int     dc;
    int     v;
    int     d;
    int     best;
    int     t[6];
    int     l[6];
    int     pred[4][16];
    longint sse[4];
    longint cost[4];
    rec   = '0;
    modes = '0;
    score = 211 * longint'(lam_mode);
    for (int i = 0; i < 16; i++) begin
        x0 = 4 * (i % 4);
        y0 = 4 * (i / 4);
        if (x0 == 0 && y0 == 0) begin
            t[0] = corner;
        end else if (y0 == 0) begin
            t[0] = top[x0 - 1];
        end else if (x0 == 0) begin
            t[0] = left[y0 - 1];
        end else begin
            t[0] = rec[(y0 - 1) * 16 + x0 - 1];
        end
        for (int k = 0; k < 4; k++) begin
            t[k + 1] = (y0 == 0) ? top[x0 + k] : rec[(y0 - 1) * 16 + x0 + k];
            l[k + 1] = (x0 == 0) ? left[y0 + k] : rec[(y0 + k) * 16 + x0 - 1];
        end
        if (y0 == 0) begin
            t[5] = top[x0 + 4];
        end else if (x0 < 12) begin
            t[5] = rec[(y0 - 1) * 16 + x0 + 4];
        end else begin
            t[5] = top[16];
        end
        l[0] = t[0];
        l[5] = l[4];
        dc = (t[1] + t[2] + t[3] + t[4] + l[1] + l[2] + l[3] + l[4] + 4) >> 3;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                v = t[c + 1] + l[r + 1] - t[0];
                pred[0][r * 4 + c] = dc;
                pred[1][r * 4 + c] = (v < 0) ? 0 : ((v > 255) ? 255 : v);
                pred[2][r * 4 + c] = smooth3(t[c], t[c + 1], t[c + 2]);
                pred[3][r * 4 + c] = smooth3(l[r], l[r + 1], l[r + 2]);
            end
        end
        best = 0;
        for (int m = 0; m < 4; m++) begin
            sse[m] = 0;
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    d = int'(src[(y0 + r) * 16 + x0 + c]) - pred[m][r * 4 + c];
                    sse[m] = sse[m] + d * d;
                end
            end
            cost[m] = 256 * sse[m] + header_cost(m) * longint'(lam_i4);
            if (cost[m] < cost[best]) begin
                best = m;
            end
        end
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                rec[(y0 + r) * 16 + x0 + c] = pixel_t'(pred[best][r * 4 + c]);
            end
        end
        modes[i] = mode_t'(best);
        score    = score + 256 * sse[best] + header_cost(best) * longint'(lam_mode);
    end
endfunction

`endif

//--- verif/intra4_tb.sv
//----------------------------------------------------------------------
// Intra 4x4 mode decision testbench
//----------------------------------------------------------------------
`timescale 1ns/10ps

module intra4_tb;
    import intra4_pkg::*;

    localparam int MAX_CYCLES    = 30 * 80 + 100;
    localparam int START_TO_DONE = 66;

    logic       clk;
    logic       rst_n;
    logic       start_i;
    lambda_t    lam_i4;
    lambda_t    lam_mode;
    mb_t        ysrc;
    pixel_t     corner;
    top_edge_t  top;
    left_edge_t left;
    mb_t        yout;
    mb_modes_t  modes;
    score_t     score;
    logic       done;

    mb_t        exp_recon;
    mb_modes_t  exp_modes;
    score_t     exp_score;
    integer     seed        = 32'h6f83_b5b8;
    int         errors      = 0;
    int         tests       = 0;
    int         passed      = 0;
    int         done_seen   = 0;
    int         cycle       = 0;
    int         start_cycle = 0;
    logic       prev_done   = 1'b0;

    `include "intra4_ref.svh"

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk_o(clk));

    intra4_top uut (
        .clk(clk), .rst_n(rst_n), .start_i(start_i),
        .lambda_i4_i(lam_i4), .lambda_mode_i(lam_mode),
        .ysrc_i(ysrc), .top_left_i(corner), .top_i(top), .left_i(left),
        .yout_o(yout), .modes_o(modes), .score_o(score), .done_o(done)
    );

    task automatic fill_random();
        for (int k = 0; k < 256; k++) begin
            ysrc[k] = pixel_t'($random(seed));
        end
        for (int k = 0; k < 20; k++) begin
            top[k] = pixel_t'($random(seed));
        end
        for (int k = 0; k < 16; k++) begin
            left[k] = pixel_t'($random(seed));
        end
        corner = pixel_t'($random(seed));
    endtask

    // Ramp edges; kind 0 copies top down, 1 copies left across, 2 is top+left-corner
    task automatic fill_structured(input int kind);
        int v;
        for (int k = 0; k < 20; k++) begin
            top[k] = pixel_t'(16 + 9 * k);
        end
        for (int k = 0; k < 16; k++) begin
            left[k] = pixel_t'(40 + 11 * k);
        end
        corner = 8'd20;
        for (int y = 0; y < 16; y++) begin
            for (int x = 0; x < 16; x++) begin
                v = int'(top[x]) + int'(left[y]) - int'(corner);
                if (kind == 0) begin
                    ysrc[y * 16 + x] = top[x];
                end else if (kind == 1) begin
                    ysrc[y * 16 + x] = left[y];
                end else begin
                    ysrc[y * 16 + x] = pixel_t'((v > 255) ? 255 : v);
                end
            end
        end
    endtask

    task automatic run_and_check(input string name, input bit mid_start);
        int seen0;
        int waited;
        seen0 = done_seen;
        ref_decide(ysrc, top, left, corner, lam_i4, lam_mode, exp_recon, exp_modes, exp_score);
        @(negedge clk);
        start_i     = 1'b1;
        start_cycle = cycle;
        @(negedge clk);
        start_i = 1'b0;
        if (mid_start) begin
            repeat (20) @(negedge clk);
            start_i = 1'b1;
            @(negedge clk);
            start_i = 1'b0;
        end
        waited = 0;
        while (done_seen == seen0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (done_seen == seen0) begin
            $display("%s: done_o never arrived after start", name);
            errors++;
        end
        if (mid_start) begin
            repeat (80) @(negedge clk);
            if (done_seen != seen0 + 1) begin
                $display("%s: expected one done_o pulse, saw %0d", name, done_seen - seen0);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            passed++;
        end
        $display("%-16s %s", name, (errors == err0) ? "pass" : "fail");
    endtask

    //------------------------------------------------------------------
    // Output compare on every done pulse
    //------------------------------------------------------------------
    always @(negedge clk) begin : compare_outputs
        int bad;
        if (rst_n && done) begin
            bad = 0;
            if (prev_done) begin
                $display("done_o stayed high for more than one cycle at %0t", $time);
                errors++;
            end
            if (cycle - start_cycle != START_TO_DONE) begin
                $display("Mismatch at %0t: done_o after %0d cycles, expected %0d",
                         $time, cycle - start_cycle, START_TO_DONE);
                errors++;
            end
            if (modes !== exp_modes) begin
                $display("Mismatch at %0t: modes_o %h, expected %h", $time, modes, exp_modes);
                errors++;
            end
            if (score !== exp_score) begin
                $display("Mismatch at %0t: score_o %0d, expected %0d", $time, score, exp_score);
                errors++;
            end
            for (int k = 0; k < 256; k++) begin
                if (yout[k] !== exp_recon[k]) begin
                    bad++;
                end
            end
            if (bad != 0) begin
                $display("Mismatch at %0t: yout_o differs in %0d pixels", $time, bad);
                errors++;
            end
            done_seen++;
        end
        prev_done = done;
    end

    // Cycle limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        int err0;
        start_i  = 1'b0;
        lam_i4   = '0;
        lam_mode = '0;
        ysrc     = '0;
        corner   = '0;
        top      = '0;
        left     = '0;
        rst_n    = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        err0 = errors;
        if (done !== 1'b0 || score !== '0 || modes !== '0 || yout !== '0) begin
            $display("Mismatch at %0t: outputs not cleared after reset", $time);
            errors++;
        end
        report_test("reset", err0);

        err0     = errors;
        ysrc     = {256{8'd128}};
        top      = {20{8'd128}};
        left     = {16{8'd128}};
        corner   = 8'd128;
        lam_i4   = 32'd500;
        lam_mode = 32'd300;
        run_and_check("flat", 1'b0);
        if (modes !== '0 || yout !== ysrc) begin
            $display("Mismatch at %0t: flat block did not pick DC everywhere", $time);
            errors++;
        end
        if (score !== (211 + 16 * 40) * score_t'(lam_mode)) begin
            $display("Mismatch at %0t: flat score_o %0d", $time, score);
            errors++;
        end
        report_test("flat", err0);

        for (int kind = 0; kind < 3; kind++) begin
            err0 = errors;
            fill_structured(kind);
            lam_i4   = 32'd120;
            lam_mode = 32'd90;
            run_and_check($sformatf("structured_%0d", kind), 1'b0);
            report_test($sformatf("structured_%0d", kind), err0);
        end

        err0 = errors;
        fill_random();
        lam_i4   = 32'h0000_ffff;
        lam_mode = 32'd1000;
        run_and_check("large_lambda", 1'b0);
        report_test("large_lambda", err0);

        for (int n = 0; n < 20; n++) begin
            err0 = errors;
            fill_random();
            lam_i4   = $random(seed) & 32'hfff;
            lam_mode = $random(seed) & 32'hfff;
            run_and_check($sformatf("random_%0d", n), 1'b0);
            report_test($sformatf("random_%0d", n), err0);
        end

        err0 = errors;
        fill_random();
        lam_i4   = 32'd700;
        lam_mode = 32'd400;
        run_and_check("busy_start", 1'b1);
        report_test("busy_start", err0);

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
logic/intra4_pkg.sv
logic/intra4_ctrl.sv
logic/intra4_context.sv
logic/intra4_predict.sv
logic/intra4_score.sv
logic/intra4_select.sv
logic/intra4_top.sv
verif/tb_clock_gen.sv
verif/intra4_tb.sv

//--- Bender.yml
package:
  name: intra4

sources:
  - files:
      - logic/intra4_pkg.sv
      - logic/intra4_ctrl.sv
      - logic/intra4_context.sv
      - logic/intra4_predict.sv
      - logic/intra4_score.sv
      - logic/intra4_select.sv
      - logic/intra4_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_clock_gen.sv
      - verif/intra4_tb.sv
